// File: verilog/host_bus_pkg.sv
////////////////////////////////////////////////////////////
// Host register port request type and the readback
// word map returned on host reads
////////////////////////////////////////////////////////////
`default_nettype none

package host_bus_pkg;

   localparam int HOST_AW = 8;
   localparam int HOST_DW = 32;

   // One request as held stable by the host
   typedef struct packed {
      logic               we;
      logic [HOST_AW-1:0] addr;
      logic [HOST_DW-1:0] wdata;
   } host_req_t;

   // Readback words, picked by the low address bits
   localparam int RB_WORDS   = 16;
   localparam int RB_AW      = $clog2(RB_WORDS);
   localparam int RB_MODE    = 9;   // sim mode and clock divider
   localparam int RB_IRQ     = 13;
   localparam int RB_IRQ_ENC = 14;
   localparam int RB_CYCLES  = 15;

endpackage

`default_nettype wire

// File: verilog/ctrl_regs_pkg.sv
////////////////////////////////////////////////////////////
// Settings bus, settings addresses, board control lines,
// interrupt sources and status inputs
////////////////////////////////////////////////////////////
`default_nettype none

package ctrl_regs_pkg;

   localparam int SR_AW = 8;
   localparam int SR_DW = 32;

   // Settings register addresses
   localparam logic [SR_AW-1:0] SR_CLOCK     = 8'd0;
   localparam logic [SR_AW-1:0] SR_SERDES    = 8'd1;
   localparam logic [SR_AW-1:0] SR_ADC       = 8'd2;
   localparam logic [SR_AW-1:0] SR_LED       = 8'd3;
   localparam logic [SR_AW-1:0] SR_PHY       = 8'd4;
   localparam logic [SR_AW-1:0] SR_LED_SRC   = 8'd8;
   localparam logic [SR_AW-1:0] SR_IRQ_MASK  = 8'd9;
   localparam logic [SR_AW-1:0] SR_IRQ_CLEAR = 8'd10;

   localparam int LED_W = 8;
   localparam int IRQ_W = 10;

   typedef struct packed {
      logic             strobe;
      logic [SR_AW-1:0] addr;
      logic [SR_DW-1:0] data;
   } set_bus_t;

   // Board control lines, MSB first as the registers map them
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_resetn;
   } ctrl_out_t;

   // Bit 0 is buffer, bit 9 is uart_tx
   typedef struct packed {
      logic uart_tx;
      logic uart_rx;
      logic pps;
      logic overrun;
      logic underrun;
      logic phy_int;
      logic i2c;
      logic spi;
      logic timer;
      logic buffer;
   } irq_src_t;

   typedef struct packed {
      logic       sim_mode;
      logic [3:0] clock_divider;
      logic       clk_status;
      logic       serdes_link_up;
   } status_in_t;

endpackage

`default_nettype wire

// File: verilog/host_port.sv
////////////////////////////////////////////////////////////
// Four-phase req/ack host port issuing settings writes
// and readback reads
////////////////////////////////////////////////////////////
`default_nettype none

module host_port
   import host_bus_pkg::*;
   import ctrl_regs_pkg::*;
(
   input  wire              dsp_clk,
   input  wire              wb_rst,
   input  wire              req_i,
   input  wire host_req_t   req_data_i,
   output logic             ack_o,
   output logic [HOST_DW-1:0] rdata_o,
   output set_bus_t         set_o,
   output logic [RB_AW-1:0] rb_addr_o,
   input  wire [HOST_DW-1:0] rb_data_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_ACK
   } state_t;

   state_t state_q;
   state_t state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (req_i) begin
               state_d = ST_ISSUE;
            end
         end
         ST_ISSUE: state_d = ST_ACK;
         ST_ACK: begin
            // Hold until the host lets go
            if (!req_i) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Read word captured once, held through ack
   always_ff @(posedge dsp_clk) begin
      if (state_q == ST_ISSUE && !req_data_i.we) begin
         rdata_o <= rb_data_i;
      end
   end

   assign ack_o       = (state_q == ST_ACK);
   assign set_o.strobe = (state_q == ST_ISSUE) && req_data_i.we;
   assign set_o.addr  = req_data_i.addr;
   assign set_o.data  = req_data_i.wdata;
   assign rb_addr_o   = req_data_i.addr[RB_AW-1:0];

endmodule

`default_nettype wire

// File: verilog/control_regs.sv
////////////////////////////////////////////////////////////
// Board control settings registers and LED source mux
////////////////////////////////////////////////////////////
`default_nettype none

module control_regs
   import ctrl_regs_pkg::*;
(
   input  wire              dsp_clk,
   input  wire              wb_rst,
   input  wire set_bus_t    set_i,
   input  wire status_in_t  status_i,
   output ctrl_out_t        ctrl_o,
   output logic [LED_W-1:0] leds_o
);

   logic [4:0]       clock_q;
   logic [3:0]       serdes_q;
   logic [3:0]       adc_q;
   logic             phy_q;
   logic [LED_W-1:0] led_sw_q;
   logic [LED_W-1:0] led_src_q;
   logic [LED_W-1:0] led_hw;

   //////////////////////////////////////////////////////////////
   // Setting registers
   //////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clock_q   <= '0;
         serdes_q  <= '0;
         adc_q     <= '0;
         phy_q     <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= '0;
      end else if (set_i.strobe) begin
         // Other addresses belong elsewhere or nowhere
         case (set_i.addr)
            SR_CLOCK:   clock_q   <= set_i.data[4:0];
            SR_SERDES:  serdes_q  <= set_i.data[3:0];
            SR_ADC:     adc_q     <= set_i.data[3:0];
            SR_PHY:     phy_q     <= set_i.data[0];
            SR_LED:     led_sw_q  <= set_i.data[LED_W-1:0];
            SR_LED_SRC: led_src_q <= set_i.data[LED_W-1:0];
            default: ;
         endcase
      end
   end

   // Low register bits onto the control lines
   assign {ctrl_o.clock_ready, ctrl_o.clk_en, ctrl_o.clk_sel} = clock_q;
   assign {ctrl_o.ser_enable, ctrl_o.ser_prbsen,
           ctrl_o.ser_loopen, ctrl_o.ser_rx_en} = serdes_q;
   assign {ctrl_o.adc_oe_a, ctrl_o.adc_on_a,
           ctrl_o.adc_oe_b, ctrl_o.adc_on_b} = adc_q;
   // PHY held out of reset unless the bit is set
   assign ctrl_o.phy_resetn = ~phy_q;

   //////////////////////////////////////////////////////////////
   // LED source mux
   //////////////////////////////////////////////////////////////

   // 1 selects hardware, 0 selects software
   assign led_hw = {{(LED_W-2){1'b0}}, status_i.clk_status, status_i.serdes_link_up};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

// File: verilog/irq_ctrl.sv
////////////////////////////////////////////////////////////
// Interrupt pending latch, mask and clear registers
////////////////////////////////////////////////////////////
`default_nettype none

module irq_ctrl
   import ctrl_regs_pkg::*;
(
   input  wire              dsp_clk,
   input  wire              wb_rst,
   input  wire set_bus_t    set_i,
   input  wire irq_src_t    irq_src_i,
   output logic [IRQ_W-1:0] pending_o,
   output logic             proc_int_o
);

   logic [IRQ_W-1:0] pending_q;
   logic [IRQ_W-1:0] mask_q;
   logic [IRQ_W-1:0] clear;

   // Write-one-to-clear
   assign clear = (set_i.strobe && set_i.addr == SR_IRQ_CLEAR) ?
                  set_i.data[IRQ_W-1:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pending_q <= '0;
         mask_q    <= '0;
      end else begin
         // A live source beats a clear of the same bit
         pending_q <= (pending_q & ~clear) | irq_src_i;
         if (set_i.strobe && set_i.addr == SR_IRQ_MASK) begin
            mask_q <= set_i.data[IRQ_W-1:0];
         end
      end
   end

   assign pending_o = pending_q;

   // Any unmasked pending source
   assign proc_int_o = |(pending_q & mask_q);

endmodule

`default_nettype wire

// File: verilog/status_readback.sv
////////////////////////////////////////////////////////////
// Cycle counter, pending interrupt encoder, readback mux
////////////////////////////////////////////////////////////
`default_nettype none

module status_readback
   import host_bus_pkg::*;
   import ctrl_regs_pkg::*;
(
   input  wire                dsp_clk,
   input  wire                wb_rst,
   input  wire [RB_AW-1:0]    rb_addr_i,
   input  wire status_in_t    status_i,
   input  wire [IRQ_W-1:0]    pending_i,
   output logic [HOST_DW-1:0] rb_data_o
);

   logic [HOST_DW-1:0] cycle_count;
   logic [HOST_DW-1:0] irq_enc;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
      end
   end

   // Lowest pending index plus one, zero when idle
   always_comb begin
      irq_enc = '0;
      for (int i = IRQ_W - 1; i >= 0; i--) begin
         if (pending_i[i]) begin
            irq_enc = HOST_DW'(i + 1);
         end
      end
   end

   always_comb begin
      case (rb_addr_i)
         RB_MODE:    rb_data_o = {status_i.sim_mode, 27'b0, status_i.clock_divider};
         RB_IRQ:     rb_data_o = {{(HOST_DW-IRQ_W){1'b0}}, pending_i};
         RB_IRQ_ENC: rb_data_o = irq_enc;
         RB_CYCLES:  rb_data_o = cycle_count;
         default:    rb_data_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/u2_ctrl_core.sv
////////////////////////////////////////////////////////////
// Housekeeping slice top level
////////////////////////////////////////////////////////////
`default_nettype none

module u2_ctrl_core
   import host_bus_pkg::*;
   import ctrl_regs_pkg::*;
(
   input  wire                dsp_clk,
   input  wire                wb_rst,
   input  wire                req_i,
   input  wire host_req_t     req_data_i,
   output logic               ack_o,
   output logic [HOST_DW-1:0] rdata_o,
   input  wire irq_src_t      irq_src_i,
   input  wire status_in_t    status_i,
   output ctrl_out_t          ctrl_o,
   output logic [LED_W-1:0]   leds_o,
   output logic               proc_int_o
);

   set_bus_t           set_bus;
   logic [RB_AW-1:0]   rb_addr;
   logic [HOST_DW-1:0] rb_data;
   logic [IRQ_W-1:0]   pending;

   host_port u_host_port (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .req_i      (req_i),
      .req_data_i (req_data_i),
      .ack_o      (ack_o),
      .rdata_o    (rdata_o),
      .set_o      (set_bus),
      .rb_addr_o  (rb_addr),
      .rb_data_i  (rb_data)
   );

   control_regs u_control_regs (
      .dsp_clk  (dsp_clk),
      .wb_rst   (wb_rst),
      .set_i    (set_bus),
      .status_i (status_i),
      .ctrl_o   (ctrl_o),
      .leds_o   (leds_o)
   );

   irq_ctrl u_irq_ctrl (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .set_i      (set_bus),
      .irq_src_i  (irq_src_i),
      .pending_o  (pending),
      .proc_int_o (proc_int_o)
   );

   status_readback u_status_readback (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .rb_addr_i (rb_addr),
      .status_i  (status_i),
      .pending_i (pending),
      .rb_data_o (rb_data)
   );

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
////////////////////////////////////////////////////////////
// Testbench clock and power-on reset
////////////////////////////////////////////////////////////
`default_nettype none

module tb_clkgen (
   output logic dsp_clk,
   output logic wb_rst
);

   timeunit 1ns;
   timeprecision 1ps;

   // 10 ns period
   initial begin
      dsp_clk = 1'b0;
      forever #5 dsp_clk = ~dsp_clk;
   end

   // Reset held for three rising edges
   initial begin
      wb_rst = 1'b1;
      repeat (3) @(posedge dsp_clk);
      wb_rst <= 1'b0;
   end

endmodule

`default_nettype wire

// File: sim/u2_ctrl_core_checker.sv
////////////////////////////////////////////////////////////
// Compares read data and control outputs with the
// values expected by the trace
////////////////////////////////////////////////////////////
`default_nettype none

module u2_ctrl_core_checker
   import host_bus_pkg::*;
   import ctrl_regs_pkg::*;
(
   input  wire                dsp_clk,
   input  wire                wb_rst,
   input  wire host_req_t     req_data_i,
   input  wire                ack_i,
   input  wire [HOST_DW-1:0]  rdata_i,
   input  wire ctrl_out_t     ctrl_i,
   input  wire [LED_W-1:0]    leds_i,
   input  wire                proc_int_i,
   input  wire                read_gt_i,
   input  wire [HOST_DW-1:0]  read_exp_i,
   input  wire                check_i,
   input  wire ctrl_out_t     exp_ctrl_i,
   input  wire [LED_W-1:0]    exp_leds_i,
   input  wire                exp_int_i,
   output int                 mismatches_o
);

   timeunit 1ns;
   timeprecision 1ps;

   int                 count = 0;
   logic               read_done = 1'b0;
   logic [HOST_DW-1:0] last_rdata = '0;

   assign mismatches_o = count;

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      count++;
   endtask

   // Outputs are sampled mid-cycle, away from the driving edge
   always @(negedge dsp_clk) begin
      if (!wb_rst) begin
         if (!ack_i) begin
            read_done = 1'b0;
         end else if (!read_done && !req_data_i.we) begin
            // One compare per read, on the first cycle of ack
            read_done = 1'b1;
            if (read_gt_i) begin
               if (rdata_i <= last_rdata) begin
                  $display("Mismatch at %0t: rdata_o got %h expected above %h",
                           $time, rdata_i, last_rdata);
                  count++;
               end
            end else if (rdata_i !== read_exp_i) begin
               report_mismatch("rdata_o", rdata_i, read_exp_i);
            end
            last_rdata = rdata_i;
         end
         if (check_i) begin
            if (ctrl_i !== exp_ctrl_i) begin
               report_mismatch("ctrl_o", {18'b0, ctrl_i}, {18'b0, exp_ctrl_i});
            end
            if (leds_i !== exp_leds_i) begin
               report_mismatch("leds_o", {24'b0, leds_i}, {24'b0, exp_leds_i});
            end
            if (proc_int_i !== exp_int_i) begin
               report_mismatch("proc_int_o", {31'b0, proc_int_i}, {31'b0, exp_int_i});
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/u2_ctrl_core_asserts.sv
////////////////////////////////////////////////////////////
// Handshake and interrupt rules, bound into the core
////////////////////////////////////////////////////////////
`default_nettype none

module u2_ctrl_core_asserts
   import ctrl_regs_pkg::*;
(
   input wire             dsp_clk,
   input wire             wb_rst,
   input wire             req_i,
   input wire             ack_i,
   input wire set_bus_t   set_i,
   input wire [IRQ_W-1:0] pending_i,
   input wire             proc_int_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int               fail_count = 0;
   logic [IRQ_W-1:0] mask_written;

   // Mask as last written over the settings bus
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         mask_written <= '0;
      end else if (set_i.strobe && set_i.addr == SR_IRQ_MASK) begin
         mask_written <= set_i.data[IRQ_W-1:0];
      end
   end

   ack_needs_req: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      $rose(ack_i) |-> req_i)
      else begin
         $error("ack_o rose while req_i was low");
         fail_count++;
      end

   // Held until the host lets go
   ack_holds: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      (ack_i && req_i) |=> ack_i)
      else begin
         $error("ack_o fell while req_i was still high");
         fail_count++;
      end

   strobe_single: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      set_i.strobe |=> !set_i.strobe)
      else begin
         $error("settings strobe lasted more than one cycle");
         fail_count++;
      end

   int_masked: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      proc_int_i |-> |(pending_i & mask_written))
      else begin
         $error("proc_int_o high without a masked-in pending bit");
         fail_count++;
      end

endmodule

bind u2_ctrl_core u2_ctrl_core_asserts u_asserts (
   .dsp_clk    (dsp_clk),
   .wb_rst     (wb_rst),
   .req_i      (req_i),
   .ack_i      (ack_o),
   .set_i      (set_bus),
   .pending_i  (pending),
   .proc_int_i (proc_int_o)
);

`default_nettype wire

// File: sim/u2_ctrl_core_tb.sv
////////////////////////////////////////////////////////////
// Testbench top: trace reader, host handshake driver,
// source driver and watchdog
////////////////////////////////////////////////////////////
`default_nettype none

module u2_ctrl_core_tb
   import host_bus_pkg::*;
   import ctrl_regs_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   logic               dsp_clk;
   logic               wb_rst;
   logic               req;
   host_req_t          req_data;
   logic               ack;
   logic [HOST_DW-1:0] rdata;
   irq_src_t           irq_src;
   status_in_t         status;
   ctrl_out_t          ctrl;
   logic [LED_W-1:0]   leds;
   logic               proc_int;

   // Expectations handed to the checker
   logic               read_gt;
   logic [HOST_DW-1:0] read_exp;
   logic               check;
   ctrl_out_t          exp_ctrl;
   logic [LED_W-1:0]   exp_leds;
   logic               exp_int;

   int                 mismatches;
   int                 other_errors;
   int                 n_ops;
   integer             seed;
   byte                op_q[$];
   logic [31:0]        a_q[$];
   logic [31:0]        b_q[$];
   logic [31:0]        c_q[$];

   tb_clkgen u_clkgen (
      .dsp_clk (dsp_clk),
      .wb_rst  (wb_rst)
   );

   u2_ctrl_core i_dut (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .req_i      (req),
      .req_data_i (req_data),
      .ack_o      (ack),
      .rdata_o    (rdata),
      .irq_src_i  (irq_src),
      .status_i   (status),
      .ctrl_o     (ctrl),
      .leds_o     (leds),
      .proc_int_o (proc_int)
   );

   u2_ctrl_core_checker u_checker (
      .dsp_clk      (dsp_clk),
      .wb_rst       (wb_rst),
      .req_data_i   (req_data),
      .ack_i        (ack),
      .rdata_i      (rdata),
      .ctrl_i       (ctrl),
      .leds_i       (leds),
      .proc_int_i   (proc_int),
      .read_gt_i    (read_gt),
      .read_exp_i   (read_exp),
      .check_i      (check),
      .exp_ctrl_i   (exp_ctrl),
      .exp_leds_i   (exp_leds),
      .exp_int_i    (exp_int),
      .mismatches_o (mismatches)
   );

   ////////////////////////////////////////////////////////////
   // Trace and host handshake
   ////////////////////////////////////////////////////////////

   task automatic load_trace();
      int          fd;
      string       line;
      byte         op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen("sim/u2_ctrl_core_trace.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the trace file sim/u2_ctrl_core_trace.txt");
         other_errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         a = '0;
         b = '0;
         c = '0;
         // Skip comments and blank lines
         if (line.len() > 1 && line[0] != "#") begin
            void'($sscanf(line, "%c %h %h %h", op, a, b, c));
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
         end
      end
      $fclose(fd);
   endtask

   task automatic host_access(input logic we, input logic [7:0] addr,
                              input logic [31:0] data);
      int waited;
      int gap;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge dsp_clk);
      @(posedge dsp_clk);
      req      <= 1'b1;
      req_data <= '{we: we, addr: addr, wdata: data};
      waited = 0;
      do begin
         @(negedge dsp_clk);
         waited++;
      end while (!ack && waited < 20);
      if (!ack) begin
         $display("No ack at %0t for the request to address %h", $time, addr);
         other_errors++;
      end
      @(posedge dsp_clk);
      req <= 1'b0;
      waited = 0;
      do begin
         @(negedge dsp_clk);
         waited++;
      end while (ack && waited < 20);
      if (ack) begin
         $display("ack still high at %0t after the request was dropped", $time);
         other_errors++;
      end
   endtask

   task automatic run_op(input byte op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] c);
      case (op)
         "W": host_access(1'b1, a[7:0], b);
         "R", "G": begin
            read_exp <= b;
            read_gt  <= (op == "G");
            host_access(1'b0, a[7:0], '0);
         end
         "S": begin
            @(posedge dsp_clk);
            irq_src <= a[IRQ_W-1:0];
            status  <= b[6:0];
            // Pending bits latch a cycle after the source
            repeat (2) @(posedge dsp_clk);
         end
         "C": begin
            @(posedge dsp_clk);
            exp_ctrl <= a[13:0];
            exp_leds <= b[LED_W-1:0];
            exp_int  <= c[0];
            check    <= 1'b1;
            @(posedge dsp_clk);
            check <= 1'b0;
         end
         default: begin
            $display("Unknown trace operation %c", op);
            other_errors++;
         end
      endcase
   endtask

   initial begin : main
      req          = 1'b0;
      req_data     = '0;
      irq_src      = '0;
      status       = '0;
      read_gt      = 1'b0;
      read_exp     = '0;
      check        = 1'b0;
      exp_ctrl     = '0;
      exp_leds     = '0;
      exp_int      = 1'b0;
      other_errors = 0;
      n_ops        = 0;
      seed         = 84822;
      load_trace();
      n_ops = op_q.size();
      wait (wb_rst === 1'b1);
      wait (wb_rst === 1'b0);
      @(posedge dsp_clk);
      for (int i = 0; i < n_ops; i++) begin
         run_op(op_q[i], a_q[i], b_q[i], c_q[i]);
      end
      repeat (2) @(posedge dsp_clk);
      $display("Errors: %0d mismatches, %0d assertion failures, %0d other failures",
               mismatches, i_dut.u_asserts.fail_count, other_errors);
      if (mismatches == 0 && other_errors == 0 && i_dut.u_asserts.fail_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // 50 cycles per trace line
   initial begin : watchdog
      wait (n_ops > 0);
      repeat (n_ops * 50) @(posedge dsp_clk);
      $display("Watchdog expired, run exceeded %0d cycles", n_ops * 50);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/u2_ctrl_core_trace.txt
# W addr data | R addr expected | G addr (read above last read) | all fields hex
# S irq status | C ctrl_o leds_o proc_int_o
C 0001 00 0
W 00 00000015
W 01 0000000a
W 02 00000006
C 2b4d 00 0
W 04 00000001
W 05 ffffffff
C 2b4c 00 0
S 000 56
W 03 000000a5
W 08 00000003
C 2b4c a6 0
R 09 80000005
S 010 56
S 000 56
R 0d 00000010
R 0e 00000005
C 2b4c a6 0
W 09 00000010
C 2b4c a6 1
S 080 56
S 000 56
R 0d 00000090
R 0e 00000005
W 0a 00000010
C 2b4c a6 0
R 0d 00000080
R 0e 00000008
W 0a 00000080
R 0e 00000000
G 0f
G 0f

// File: u2_ctrl_core.f
verilog/host_bus_pkg.sv
verilog/ctrl_regs_pkg.sv
verilog/host_port.sv
verilog/control_regs.sv
verilog/irq_ctrl.sv
verilog/status_readback.sv
verilog/u2_ctrl_core.sv
sim/tb_clkgen.sv
sim/u2_ctrl_core_checker.sv
sim/u2_ctrl_core_asserts.sv
sim/u2_ctrl_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := u2_ctrl_core_tb
FILELIST := u2_ctrl_core.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
